// ==== rtl/rv_fetch_pkg.sv ====
package rv_fetch_pkg;

  parameter int XLEN = 32;

  parameter logic [XLEN-1:0] PC_INIT = 32'h0000_0000;

  // base opcodes, bits [6:0] of the instruction word
  parameter logic [6:0] OP_JAL    = 7'b1101111;
  parameter logic [6:0] OP_JALR   = 7'b1100111;
  parameter logic [6:0] OP_BRANCH = 7'b1100011;
  parameter logic [6:0] OP_SYSTEM = 7'b1110011;
  parameter logic [6:0] OP_LOAD   = 7'b0000011;

  parameter logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  // one bus request, held by the master until it sees rvalid
  typedef struct packed {
    logic            valid;
    logic            we;
    logic [XLEN-1:0] addr;  // word address, not byte address
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic            rvalid;  // single-cycle pulse
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== rtl/sim_mem.sv ====
`timescale 1ns/1ps

module sim_mem #(
  parameter int MEM_WORDS_LOG = 10,
  parameter int MEM_LAT       = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_fetch_pkg::mem_req_t req_i,
  output rv_fetch_pkg::mem_rsp_t rsp_o
);

  localparam int XLEN  = rv_fetch_pkg::XLEN;
  localparam int WORDS = 1 << MEM_WORDS_LOG;
  localparam int CNT_W = (MEM_LAT > 1) ? $clog2(MEM_LAT) : 1;

  logic [XLEN-1:0]  mem_q [WORDS];
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic [XLEN-1:0]  rdata_q;

  logic [MEM_WORDS_LOG-1:0] waddr;

  assign waddr = req_i.addr[MEM_WORDS_LOG-1:0];  // upper address bits wrap

  // rvalid lands MEM_LAT cycles after the cycle valid was sampled
  assign rsp_o.rvalid = busy_q & (cnt_q == '0);
  assign rsp_o.rdata  = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!busy_q) begin
      if (req_i.valid) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(MEM_LAT - 1);
      end
    end else if (cnt_q == '0) begin
      busy_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // array access happens once, at the sampling edge
  always_ff @(posedge clk) begin
    if (!busy_q && req_i.valid) begin
      rdata_q <= mem_q[waddr];
      if (req_i.we) begin
        mem_q[waddr] <= req_i.wdata;
      end
    end
  end

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_fetch_pkg::mem_req_t ic_req_i,
  input  rv_fetch_pkg::mem_req_t ls_req_i,
  output rv_fetch_pkg::mem_rsp_t ic_rsp_o,
  output rv_fetch_pkg::mem_rsp_t ls_rsp_o,
  output rv_fetch_pkg::mem_req_t mem_req_o,
  input  rv_fetch_pkg::mem_rsp_t mem_rsp_i
);

  logic busy_q;
  logic owner_q;  // 1 when the load/store port holds the grant
  logic sel_ls;

  // when idle the load/store port has priority
  assign sel_ls    = busy_q ? owner_q : ls_req_i.valid;
  assign mem_req_o = sel_ls ? ls_req_i : ic_req_i;

  always_comb begin
    ic_rsp_o        = mem_rsp_i;
    ls_rsp_o        = mem_rsp_i;
    ic_rsp_o.rvalid = mem_rsp_i.rvalid & busy_q & !owner_q;
    ls_rsp_o.rvalid = mem_rsp_i.rvalid & busy_q & owner_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (!busy_q) begin
      if (mem_req_o.valid) begin
        busy_q  <= 1'b1;
        owner_q <= sel_ls;
      end
    end else if (mem_rsp_i.rvalid) begin
      busy_q <= 1'b0;  // grant ends with the response of this transaction
    end
  end

endmodule

// ==== rtl/lsu_port.sv ====
`timescale 1ns/1ps

module lsu_port (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cmd_valid_i,
  input  logic                          cmd_we_i,
  input  logic [rv_fetch_pkg::XLEN-1:0] cmd_addr_i,   // byte address, word aligned
  input  logic [rv_fetch_pkg::XLEN-1:0] cmd_wdata_i,
  output logic                          done_o,
  output logic [rv_fetch_pkg::XLEN-1:0] rdata_o,
  output rv_fetch_pkg::mem_req_t        bus_req_o,
  input  rv_fetch_pkg::mem_rsp_t        bus_rsp_i
);

  localparam int XLEN = rv_fetch_pkg::XLEN;

  logic            busy_q;
  logic            we_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;

  always_comb begin
    bus_req_o.valid = busy_q;
    bus_req_o.we    = we_q;
    bus_req_o.addr  = addr_q;
    bus_req_o.wdata = wdata_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (!busy_q && cmd_valid_i) begin  // a command during a transaction is dropped
        busy_q  <= 1'b1;
        we_q    <= cmd_we_i;
        addr_q  <= {2'b00, cmd_addr_i[XLEN-1:2]};
        wdata_q <= cmd_wdata_i;
      end else if (busy_q && bus_rsp_i.rvalid) begin
        busy_q  <= 1'b0;
        done_o  <= 1'b1;
        rdata_o <= bus_rsp_i.rdata;
      end
    end
  end

endmodule

// ==== rtl/l1i_cache.sv ====
`timescale 1ns/1ps

module l1i_cache #(
  parameter int L1I_SETS_LOG = 2
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [rv_fetch_pkg::XLEN-1:0]   pc_i,
  input  logic                            fetch_accept_i,
  output logic                            hit_o,
  output logic [rv_fetch_pkg::XLEN-1:0]   inst_o,
  output logic                            refill_done_o,
  output rv_fetch_pkg::mem_req_t          bus_req_o,
  input  rv_fetch_pkg::mem_rsp_t          bus_rsp_i
);

  localparam int XLEN   = rv_fetch_pkg::XLEN;
  localparam int SETS   = 1 << L1I_SETS_LOG;
  localparam int TAG_W  = XLEN - 3 - L1I_SETS_LOG;
  localparam int LINE_W = XLEN - 3;

  typedef enum logic [1:0] {
    S_IDLE,
    S_BEAT0,
    S_BEAT1
  } state_e;

  state_e state_q;

  logic [XLEN-1:0]         data_q [SETS][2];
  logic [TAG_W-1:0]        tag_q  [SETS];
  logic [SETS-1:0]         valid_q;
  logic [LINE_W-1:0]       line_q;  // line under refill, kept stable on the bus

  logic [TAG_W-1:0]        pc_tag;
  logic [L1I_SETS_LOG-1:0] pc_idx;
  logic                    pc_off;
  logic [L1I_SETS_LOG-1:0] fill_idx;
  logic [TAG_W-1:0]        fill_tag;
  logic                    fill_beat;

  assign pc_tag = pc_i[XLEN-1:L1I_SETS_LOG+3];
  assign pc_idx = pc_i[L1I_SETS_LOG+2:3];
  assign pc_off = pc_i[2];

  assign fill_idx  = line_q[L1I_SETS_LOG-1:0];
  assign fill_tag  = line_q[LINE_W-1:L1I_SETS_LOG];
  assign fill_beat = (state_q == S_BEAT1);  // even word first, then odd

  assign hit_o = valid_q[pc_idx] & (tag_q[pc_idx] == pc_tag);

  // the missing word is handed over in the cycle it comes off the bus
  assign refill_done_o = bus_rsp_i.rvalid & (state_q != S_IDLE) &
                         (pc_i[XLEN-1:3] == line_q) & (pc_off == fill_beat);

  assign inst_o = refill_done_o ? bus_rsp_i.rdata : data_q[pc_idx][pc_off];

  always_comb begin
    bus_req_o.valid = (state_q != S_IDLE);
    bus_req_o.we    = 1'b0;
    bus_req_o.addr  = {2'b00, line_q, fill_beat};
    bus_req_o.wdata = '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (!hit_o) begin
            line_q          <= pc_i[XLEN-1:3];
            valid_q[pc_idx] <= 1'b0;  // old line in this set is about to be overwritten
            state_q         <= S_BEAT0;
          end
        end
        S_BEAT0: begin
          if (bus_rsp_i.rvalid) begin
            data_q[fill_idx][0] <= bus_rsp_i.rdata;
            state_q             <= S_BEAT1;
          end
        end
        S_BEAT1: begin
          if (bus_rsp_i.rvalid) begin
            data_q[fill_idx][1] <= bus_rsp_i.rdata;
            tag_q[fill_idx]     <= fill_tag;
            valid_q[fill_idx]   <= 1'b1;
            state_q             <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase

      // placed last so that it also wins over a refill finishing in the same cycle
      if (fetch_accept_i && inst_o == rv_fetch_pkg::INST_FENCE_I) begin
        valid_q <= '0;
      end
    end
  end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                          clk,
  input  logic                          rst,
  output logic [rv_fetch_pkg::XLEN-1:0] pc_o,
  output logic [rv_fetch_pkg::XLEN-1:0] inst_o,
  output logic                          valid_o,
  output logic                          ready_o,
  output logic                          bad_speculation_o,
  output logic                          fetch_accept_o,
  input  logic [rv_fetch_pkg::XLEN-1:0] npc_i,
  input  logic                          pc_change_i,
  input  logic                          pc_retire_i,
  input  logic                          prev_valid_i,
  input  logic                          next_ready_i,
  input  logic                          hit_i,
  input  logic [rv_fetch_pkg::XLEN-1:0] inst_i,
  input  logic                          refill_done_i
);

  localparam int XLEN = rv_fetch_pkg::XLEN;

  logic [XLEN-1:0] pc_q;
  logic            branch_hazard_q;
  logic            load_hazard_q;
  logic            btb_valid_q;
  logic [XLEN-1:0] btb_pc_q;    // pc of the branch that owns the entry
  logic [XLEN-1:0] btb_tgt_q;
  logic            spec_q;
  logic [XLEN-1:0] spec_pc_q;   // target we guessed

  logic [6:0]      opcode;
  logic            is_branch;
  logic            is_load;
  logic            hazard;
  logic            predict;

  assign opcode    = inst_i[6:0];
  assign is_branch = (opcode == rv_fetch_pkg::OP_JAL) | (opcode == rv_fetch_pkg::OP_JALR) |
                     (opcode == rv_fetch_pkg::OP_BRANCH) | (opcode == rv_fetch_pkg::OP_SYSTEM);
  assign is_load   = (opcode == rv_fetch_pkg::OP_LOAD);
  assign hazard    = branch_hazard_q | load_hazard_q;
  assign predict   = btb_valid_q & !spec_q & (btb_pc_q == pc_q);

  assign pc_o              = pc_q;
  assign inst_o            = inst_i;
  assign valid_o           = (hit_i | refill_done_i) & !hazard;
  assign ready_o           = !valid_o;
  assign fetch_accept_o    = valid_o & next_ready_i;
  assign bad_speculation_o = prev_valid_i & spec_q & (npc_i != spec_pc_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q            <= rv_fetch_pkg::PC_INIT;
      branch_hazard_q <= 1'b0;
      load_hazard_q   <= 1'b0;
      btb_valid_q     <= 1'b0;
      spec_q          <= 1'b0;
    end else if (bad_speculation_o) begin
      pc_q            <= npc_i;  // whatever was fetched past the guess is squashed
      spec_q          <= 1'b0;
      branch_hazard_q <= 1'b0;
      load_hazard_q   <= 1'b0;
    end else begin
      if (prev_valid_i) begin
        if (spec_q) begin
          spec_q <= 1'b0;  // guess confirmed, the oldest resolution belongs to it
        end else if (hazard && (pc_change_i || pc_retire_i)) begin
          pc_q            <= npc_i;
          branch_hazard_q <= 1'b0;
          load_hazard_q   <= 1'b0;
        end
        // pc still sits on the stalled branch here
        if (pc_change_i && branch_hazard_q && !spec_q) begin
          btb_valid_q <= 1'b1;
          btb_pc_q    <= pc_q;
          btb_tgt_q   <= npc_i;
        end
      end

      if (fetch_accept_o) begin
        if (is_branch) begin
          if (predict) begin
            pc_q      <= btb_tgt_q;
            spec_pc_q <= btb_tgt_q;
            spec_q    <= 1'b1;
          end else begin
            branch_hazard_q <= 1'b1;
          end
        end else if (is_load) begin
          load_hazard_q <= 1'b1;  // pc moves on only once the load retires
        end else begin
          pc_q <= pc_q + 32'd4;
        end
      end
    end
  end

endmodule

// ==== rtl/rv_fetch_top.sv ====
`timescale 1ns/1ps

module rv_fetch_top #(
  parameter int L1I_SETS_LOG  = 2,
  parameter int MEM_WORDS_LOG = 10,
  parameter int MEM_LAT       = 2
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_fetch_pkg::XLEN-1:0] npc_i,
  input  logic                          pc_change_i,
  input  logic                          pc_retire_i,
  input  logic                          prev_valid_i,
  input  logic                          next_ready_i,
  output logic [rv_fetch_pkg::XLEN-1:0] pc_o,
  output logic [rv_fetch_pkg::XLEN-1:0] inst_o,
  output logic                          valid_o,
  output logic                          ready_o,
  output logic                          bad_speculation_o,
  input  logic                          cmd_valid_i,
  input  logic                          cmd_we_i,
  input  logic [rv_fetch_pkg::XLEN-1:0] cmd_addr_i,
  input  logic [rv_fetch_pkg::XLEN-1:0] cmd_wdata_i,
  output logic                          done_o,
  output logic [rv_fetch_pkg::XLEN-1:0] rdata_o
);

  logic                          hit;
  logic [rv_fetch_pkg::XLEN-1:0] cache_inst;
  logic                          just_refilled;
  logic                          fetch_accept;

  rv_fetch_pkg::mem_req_t ic_req, ls_req, mem_req;
  rv_fetch_pkg::mem_rsp_t ic_rsp, ls_rsp, mem_rsp;

  fetch_unit fetch_unit_inst (
    .clk, .rst, .pc_o, .inst_o, .valid_o, .ready_o, .bad_speculation_o,
    .fetch_accept_o(fetch_accept), .npc_i, .pc_change_i, .pc_retire_i,
    .prev_valid_i, .next_ready_i, .hit_i(hit), .inst_i(cache_inst),
    .refill_done_i(just_refilled)
  );

  l1i_cache #(.L1I_SETS_LOG(L1I_SETS_LOG)) l1i_cache_inst (
    .clk, .rst, .pc_i(pc_o), .fetch_accept_i(fetch_accept), .hit_o(hit),
    .inst_o(cache_inst), .refill_done_o(just_refilled),
    .bus_req_o(ic_req), .bus_rsp_i(ic_rsp)
  );

  lsu_port lsu_port_inst (
    .clk, .rst, .cmd_valid_i, .cmd_we_i, .cmd_addr_i, .cmd_wdata_i,
    .done_o, .rdata_o, .bus_req_o(ls_req), .bus_rsp_i(ls_rsp)
  );

  mem_arbiter mem_arbiter_inst (
    .clk, .rst, .ic_req_i(ic_req), .ls_req_i(ls_req), .ic_rsp_o(ic_rsp),
    .ls_rsp_o(ls_rsp), .mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
  );

  sim_mem #(.MEM_WORDS_LOG(MEM_WORDS_LOG), .MEM_LAT(MEM_LAT)) sim_mem_inst (
    .clk, .rst, .req_i(mem_req), .rsp_o(mem_rsp)
  );

endmodule

// ==== verif/tb_rv_fetch.sv ====
`timescale 1ns/1ps

module tb_rv_fetch;

  localparam int PROG_WORDS      = 25;
  localparam int DATA_WORDS      = 8;
  localparam int LOOP_LEN        = 17;  // words 0x00..0x40, fetched twice
  localparam int WATCHDOG_CYCLES = 200 * 2 * LOOP_LEN;

  localparam logic [31:0] DATA_BASE     = 32'h0000_0800;
  localparam logic [31:0] INST_JAL_LOOP = 32'hfc1f_f06f;  // jal x0, -64
  localparam logic [31:0] INST_BEQ_BACK = 32'hfe00_0ce3;  // beq x0, x0, -8
  localparam logic [31:0] INST_LW       = 32'h0000_2103;  // lw x2, 0(x0)
  localparam logic [31:0] INST_JAL_SMC  = 32'hff5f_f06f;  // jal x0, -12

  logic        clk;
  logic        rst;
  logic [31:0] npc_i;
  logic        pc_change_i;
  logic        pc_retire_i;
  logic        prev_valid_i;
  logic        next_ready_i;
  logic [31:0] pc_o;
  logic [31:0] inst_o;
  logic        valid_o;
  logic        ready_o;
  logic        bad_speculation_o;
  logic        cmd_valid_i;
  logic        cmd_we_i;
  logic [31:0] cmd_addr_i;
  logic [31:0] cmd_wdata_i;
  logic        done_o;
  logic [31:0] rdata_o;

  logic [31:0] shadow [int];  // word index to contents, follows every store
  logic [31:0] prog [PROG_WORDS];

  rv_fetch_top rv_fetch_top_inst (
    .clk, .rst, .npc_i, .pc_change_i, .pc_retire_i, .prev_valid_i, .next_ready_i,
    .pc_o, .inst_o, .valid_o, .ready_o, .bad_speculation_o,
    .cmd_valid_i, .cmd_we_i, .cmd_addr_i, .cmd_wdata_i, .done_o, .rdata_o
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] alu_word(input int k);
    return 32'h0000_8093 | (32'(k) << 20);  // addi x1, x1, k
  endfunction

  function automatic logic [31:0] expected_inst(input logic [31:0] pc);
    if (shadow.exists(int'(pc >> 2))) begin
      return shadow[int'(pc >> 2)];
    end
    return 'x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // every task below starts and ends 2 ns after a rising edge
  task automatic lsu_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    cmd_valid_i = 1'b1;
    cmd_we_i    = we;
    cmd_addr_i  = addr;
    cmd_wdata_i = wdata;
    if (we) begin
      shadow[int'(addr >> 2)] = wdata;
    end
    @(posedge clk);
    #2;
    cmd_valid_i = 1'b0;
    while (!done_o) begin
      @(posedge clk);
      #2;
    end
    rdata = rdata_o;
  endtask

  task automatic fetch_expect(input logic [31:0] pc_exp, output logic [31:0] inst);
    next_ready_i = 1'b1;
    @(negedge clk);
    while (!valid_o) begin
      @(negedge clk);
    end
    check_value("pc_o", pc_o, pc_exp);
    inst = inst_o;
    @(posedge clk);
    #2;
    next_ready_i = 1'b0;
  endtask

  task automatic expect_stall(input int cycles);
    next_ready_i = 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      check_value("valid_o", {31'b0, valid_o}, 32'd0);
    end
    @(posedge clk);
    #2;
    next_ready_i = 1'b0;
  endtask

  task automatic resolve(input logic [31:0] npc, input logic change, input logic bad_exp);
    prev_valid_i = 1'b1;
    npc_i        = npc;
    pc_change_i  = change;
    pc_retire_i  = !change;
    @(negedge clk);
    check_value("bad_speculation_o", {31'b0, bad_speculation_o}, {31'b0, bad_exp});
    @(posedge clk);
    #2;
    prev_valid_i = 1'b0;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
  endtask

  // outputs are settled at the falling edge, the accept happens at the next rising one
  always @(negedge clk) begin
    if (!rst) begin
      check_value("ready_o", {31'b0, ready_o}, {31'b0, !valid_o});
      if (valid_o && next_ready_i) begin
        check_value("inst_o", inst_o, expected_inst(pc_o));
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] data;
    logic [31:0] inst;
    logic [31:0] addrs [$];

    void'($urandom(55));
    clk          = 1'b0;
    rst          = 1'b1;
    npc_i        = '0;
    pc_change_i  = 1'b0;
    pc_retire_i  = 1'b0;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_we_i     = 1'b0;
    cmd_addr_i   = '0;
    cmd_wdata_i  = '0;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = alu_word(i);
    end
    prog[16] = INST_JAL_LOOP;
    prog[19] = INST_BEQ_BACK;
    prog[20] = INST_LW;
    prog[22] = rv_fetch_pkg::INST_FENCE_I;
    prog[24] = INST_JAL_SMC;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    // the cache refills line 0 while stores run, so words go out in address order
    for (int i = 0; i < PROG_WORDS; i++) begin
      lsu_access(1'b1, 32'(4 * i), prog[i], data);
      addrs.push_back(32'(4 * i));
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      lsu_access(1'b1, DATA_BASE + 32'(4 * i), $urandom, data);
      addrs.push_back(DATA_BASE + 32'(4 * i));
    end
    foreach (addrs[i]) begin
      lsu_access(1'b0, addrs[i], 32'h0, data);
      check_value("rdata_o", data, shadow[int'(addrs[i] >> 2)]);
    end

    // two passes over the loop, each closed by a jal resolved without the BTB
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < LOOP_LEN; i++) begin
        fetch_expect(32'(4 * i), inst);
      end
      expect_stall(3 + int'($urandom % 8));
      resolve(pass == 0 ? 32'h0 : 32'h44, 1'b0, 1'b0);
    end

    fetch_expect(32'h44, inst);
    fetch_expect(32'h48, inst);
    fetch_expect(32'h4c, inst);
    expect_stall(3);  // BTB is still empty
    resolve(32'h44, 1'b1, 1'b0);
    fetch_expect(32'h44, inst);
    fetch_expect(32'h48, inst);
    fetch_expect(32'h4c, inst);
    fetch_expect(32'h44, inst);  // predicted target
    resolve(32'h44, 1'b1, 1'b0);
    fetch_expect(32'h48, inst);
    fetch_expect(32'h4c, inst);
    fetch_expect(32'h44, inst);  // predicted again, this time the branch falls through
    resolve(32'h50, 1'b0, 1'b1);

    fetch_expect(32'h50, inst);
    expect_stall(3 + int'($urandom % 8));
    resolve(32'h54, 1'b0, 1'b0);
    fetch_expect(32'h54, inst);

    fetch_expect(32'h58, inst);
    fetch_expect(32'h5c, inst);
    fetch_expect(32'h60, inst);
    lsu_access(1'b1, 32'h54, alu_word(200), data);  // 0x54 left the cache with the fence
    lsu_access(1'b1, 32'h5c, alu_word(201), data);  // 0x5c is still cached here
    resolve(32'h58, 1'b0, 1'b0);
    fetch_expect(32'h58, inst);
    fetch_expect(32'h5c, inst);
    check_value("inst_o", inst, alu_word(201));
    fetch_expect(32'h60, inst);
    resolve(32'h54, 1'b0, 1'b0);
    fetch_expect(32'h54, inst);
    check_value("inst_o", inst, alu_word(200));

    repeat (2) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== rv_fetch.f ====
rtl/rv_fetch_pkg.sv
rtl/sim_mem.sv
rtl/mem_arbiter.sv
rtl/lsu_port.sv
rtl/l1i_cache.sv
rtl/fetch_unit.sv
rtl/rv_fetch_top.sv
verif/tb_rv_fetch.sv

// ==== Makefile ====
SIM      ?= verilator
TOP      ?= tb_rv_fetch
FILELIST ?= rv_fetch.f
FLAGS    ?= --binary --timing --timescale 1ns/1ps --top-module $(TOP)
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
